// File: logic/blockMemory.sv
// card storage: byte-wide single-port array with registered read
`timescale 1ns/1ps
`include "sdCard_settings.svh"

module blockMemory (
   input  logic              sclk,
   input  logic              memWrite,
   input  sdCardPkg::memAddrT memAddr,
   input  sdCardPkg::byteT   memWData,
   output sdCardPkg::byteT   memRData
);
   import sdCardPkg::*;

   byteT mem [0:`MEM_DEPTH-1];

   always_ff @(posedge sclk) begin
      if (memWrite) begin
         mem[memAddr] <= memWData;
      end
      memRData <= mem[memAddr];    // read data one clock after the address
   end

endmodule

// File: logic/cardController.sv
// card controller: power-up wait, command decode, init state, response building and block transfers
`timescale 1ns/1ps
`include "sdCard_settings.svh"

module cardController (
   input  logic                sclk,
   input  logic                rstn,
   input  logic                ncs,
   input  logic                cmdValid,
   input  sdCardPkg::cmdIndexT cmdIndex,
   input  sdCardPkg::cmdArgT   cmdArg,
   input  logic                dataByteValid,
   input  sdCardPkg::byteT     dataByte,
   input  logic                blockDone,
   input  logic                respDone,
   input  sdCardPkg::byteT     memRData,
   output logic                cmdListen,
   output logic                writeListen,
   output logic                respLoad,
   output sdCardPkg::respT     respWord,
   output sdCardPkg::respLenT  respLen,
   output logic                holdLow,
   output logic                memWrite,
   output sdCardPkg::memAddrT  memAddr,
   output sdCardPkg::byteT     memWData
);
   import sdCardPkg::*;

   cardStateT                   state;
   logic [6:0]                  powerCnt;
   logic [7:0]                  gapCnt;      // ncr, nac and busy clocks
   logic [`BLOCK_OFFSET_BITS:0] xferCnt;     // block bytes, then the crc
   blockIdxT                    blockIdx;
   byteOffsetT                  byteOff;
   logic                        appCmd;      // previous command was CMD55
   logic                        ready;       // set by ACMD41
   logic                        readCmd;
   logic                        writeCmd;
   respT                        cmdResp;     // held response, includes the CMD8 echo
   respLenT                     cmdRespLen;

   // decode of the incoming command
   byteT    r1Idle;
   logic [3:0] vhsEcho;
   respT    nextResp;
   respLenT nextLen;
   logic    nextRead;
   logic    nextWrite;

   assign r1Idle  = {7'b0, ~ready};
   assign vhsEcho = (cmdArg[11:8] == `CARD_VHS) ? cmdArg[11:8] : 4'b0000;

   always_comb begin
      nextResp  = {r1Idle | 8'h04, 32'b0};   // illegal command by default
      nextLen   = 6'd8;
      nextRead  = 1'b0;
      nextWrite = 1'b0;
      if (appCmd) begin
         if (cmdIndex == 6'd41) begin
            nextResp = '0;
         end
      end else begin
         case (cmdIndex)
            6'd0:  nextResp = {8'h01, 32'b0};
            6'd8: begin                        // R7
               nextResp = {r1Idle, 20'b0, vhsEcho, cmdArg[7:0]};
               nextLen  = 6'd40;
            end
            6'd55: nextResp = {r1Idle, 32'b0};
            6'd58: begin                       // R3, busy bit reports init done
               nextResp = {r1Idle, (`CARD_OCR | {ready, 31'b0})};
               nextLen  = 6'd40;
            end
            6'd17, 6'd24: begin
               if (ready) begin
                  nextResp  = '0;
                  nextRead  = (cmdIndex == 6'd17);
                  nextWrite = (cmdIndex == 6'd24);
               end
            end
            default: ;
         endcase
      end
   end

   // shifter feed
   always_comb begin
      respLoad = 1'b0;
      respWord = cmdResp;
      respLen  = cmdRespLen;
      case (state)
         waitNcr: respLoad = (gapCnt == `N_CR_BYTES * 8 - 1);
         readGap: begin
            respLoad = (gapCnt == `N_AC_BYTES * 8 - 1);
            respWord = {`START_TOKEN, 32'b0};
            respLen  = 6'd8;
         end
         readBlock: begin
            respLoad = respDone && (xferCnt <= `BLOCK_BYTES);
            if (xferCnt == `BLOCK_BYTES) begin
               respWord = {`DATA_CRC, 24'b0};
               respLen  = 6'd16;
            end else begin
               respWord = {memRData, 32'b0};  // prefetched during the previous byte
               respLen  = 6'd8;
            end
         end
         writeData: begin
            respLoad = blockDone;
            respWord = {`DATA_ACCEPTED, 32'b0};
            respLen  = 6'd8;
         end
         default: ;
      endcase
   end

   assign cmdListen   = (state == idle);
   assign writeListen = (state == writeData);
   assign holdLow     = (state == dataResp) || (state == busy);
   assign byteOff     = xferCnt[`BLOCK_OFFSET_BITS-1:0];
   assign memAddr     = {blockIdx, byteOff};
   assign memWrite    = writeListen && dataByteValid;
   assign memWData    = dataByte;

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         state    <= powerUp;
         powerCnt <= '0;
         gapCnt   <= '0;
         xferCnt  <= '0;
         appCmd   <= 1'b0;
         ready    <= 1'b0;
         readCmd  <= 1'b0;
         writeCmd <= 1'b0;
      end else if (ncs && state != powerUp) begin
         state <= idle;                     // deselect aborts any transfer
      end else begin
         case (state)
            powerUp: begin
               powerCnt <= powerCnt + 7'd1;
               if (powerCnt == `POWERUP_CLOCKS - 1) state <= idle;
            end
            idle: begin
               if (cmdValid) begin
                  cmdResp    <= nextResp;
                  cmdRespLen <= nextLen;
                  readCmd    <= nextRead;
                  writeCmd   <= nextWrite;
                  blockIdx   <= cmdArg[`MEM_BLOCK_BITS-1:0];
                  appCmd     <= !appCmd && (cmdIndex == 6'd55);
                  if (!appCmd && cmdIndex == 6'd0) ready <= 1'b0;
                  if (appCmd && cmdIndex == 6'd41) ready <= 1'b1;
                  gapCnt <= '0;
                  state  <= waitNcr;
               end
            end
            waitNcr: begin
               gapCnt <= gapCnt + 8'd1;
               if (respLoad) state <= respond;
            end
            respond: begin
               if (respDone) begin
                  gapCnt  <= '0;
                  xferCnt <= '0;
                  if (readCmd) state <= readGap;
                  else if (writeCmd) state <= writeData;
                  else state <= idle;
               end
            end
            readGap: begin
               gapCnt <= gapCnt + 8'd1;
               if (respLoad) state <= readBlock;  // token loaded
            end
            readBlock: begin
               if (respDone) begin
                  xferCnt <= xferCnt + 1'b1;
                  if (!respLoad) state <= idle;   // crc has left
               end
            end
            writeData: begin
               if (dataByteValid) xferCnt <= xferCnt + 1'b1;
               if (blockDone) state <= dataResp;
            end
            dataResp: begin
               if (respDone) begin
                  gapCnt <= 8'd1;           // first busy clock goes out with this edge
                  state  <= busy;
               end
            end
            busy: begin
               gapCnt <= gapCnt + 8'd1;
               if (gapCnt == `BUSY_CYCLES - 1) state <= idle;
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

// File: logic/cmdReceiver.sv
// command receiver: frames 48-bit SPI commands from mosi and hands over index and argument
`timescale 1ns/1ps

module cmdReceiver (
   input  logic                sclk,
   input  logic                rstn,
   input  logic                ncs,
   input  logic                mosi,
   input  logic                cmdListen,
   output logic                cmdValid,
   output sdCardPkg::cmdIndexT cmdIndex,
   output sdCardPkg::cmdArgT   cmdArg
);

   // bitCnt 0 hunts the start bit, 1 waits for the transmission bit,
   // 2..39 are index and argument, 40..46 crc, 47 the end bit
   logic [5:0]  bitCnt;
   logic [37:0] fieldBits;             // index and argument, MSB first

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         bitCnt   <= 6'd0;
         cmdValid <= 1'b0;
      end else begin
         cmdValid <= 1'b0;
         if (ncs || !cmdListen) begin
            bitCnt <= 6'd0;             // drop any partial frame
         end else if (bitCnt == 6'd0) begin
            if (!mosi) begin
               bitCnt <= 6'd1;          // start bit
            end
         end else if (bitCnt == 6'd1) begin
            if (mosi) begin
               bitCnt <= 6'd2;          // host to card
            end
         end else if (bitCnt == 6'd47) begin
            cmdValid <= 1'b1;           // end bit seen
            bitCnt   <= 6'd0;
         end else begin
            bitCnt <= bitCnt + 6'd1;
         end
      end
   end

   // field capture, crc bits are not kept
   always_ff @(posedge sclk) begin
      if (bitCnt >= 6'd2 && bitCnt <= 6'd39) begin
         fieldBits <= {fieldBits[36:0], mosi};
      end
      if (bitCnt == 6'd47) begin
         cmdIndex <= fieldBits[37:32];
         cmdArg   <= fieldBits[31:0];
      end
   end

endmodule

// File: logic/dataReceiver.sv
// write data receiver: hunts the start token, delivers block bytes and swallows the data crc
`timescale 1ns/1ps
`include "sdCard_settings.svh"

module dataReceiver (
   input  logic            sclk,
   input  logic            rstn,
   input  logic            ncs,
   input  logic            mosi,
   input  logic            writeListen,
   output logic            dataByteValid,
   output sdCardPkg::byteT dataByte,
   output logic            blockDone
);
   import sdCardPkg::*;

   logic                        active;    // token found, collecting bytes
   logic [2:0]                  bitCnt;
   logic [`BLOCK_OFFSET_BITS:0] byteIdx;   // data bytes, then two crc bytes
   byteT                        window;    // last eight mosi bits
   byteT                        nextWindow;

   assign nextWindow = {window[6:0], mosi};

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         active        <= 1'b0;
         bitCnt        <= 3'd0;
         byteIdx       <= '0;
         window        <= '0;
         dataByteValid <= 1'b0;
         blockDone     <= 1'b0;
      end else begin
         dataByteValid <= 1'b0;
         blockDone     <= 1'b0;
         if (ncs || !writeListen) begin
            active <= 1'b0;
            window <= '0;                    // seven fresh ones needed before a token
         end else if (!active) begin
            window <= nextWindow;
            if (nextWindow == `START_TOKEN) begin   // anything else is shifted past
               active  <= 1'b1;
               bitCnt  <= 3'd0;
               byteIdx <= '0;
            end
         end else begin
            window <= nextWindow;
            bitCnt <= bitCnt + 3'd1;
            if (bitCnt == 3'd7) begin
               byteIdx <= byteIdx + 1'b1;
               if (byteIdx < `BLOCK_BYTES) begin
                  dataByte      <= nextWindow;
                  dataByteValid <= 1'b1;
               end else if (byteIdx == `BLOCK_BYTES + 1) begin
                  blockDone <= 1'b1;         // second crc byte gone
                  active    <= 1'b0;
                  window    <= '0;
               end
            end
         end
      end
   end

endmodule

// File: logic/responseShifter.sv
// response shifter: sends responses, tokens and data bytes on miso, MSB first, one bit per clock
`timescale 1ns/1ps

module responseShifter (
   input  logic               sclk,
   input  logic               rstn,
   input  logic               ncs,
   input  logic               respLoad,
   input  sdCardPkg::respT    respWord,
   input  sdCardPkg::respLenT respLen,
   input  logic               holdLow,
   output logic               respDone,
   output logic               miso
);
   import sdCardPkg::*;

   respT    shiftReg;
   respLenT bitsLeft;     // bits still to go after the one on miso

   always_ff @(posedge sclk) begin
      if (!rstn || ncs) begin
         bitsLeft <= '0;
         respDone <= 1'b0;
         miso     <= 1'b1;
      end else begin
         respDone <= 1'b0;
         if (respLoad) begin
            // first bit goes out right away so back-to-back words have no gap
            miso     <= respWord[39];
            shiftReg <= {respWord[38:0], 1'b0};
            bitsLeft <= respLen - 6'd1;
         end else if (bitsLeft != 6'd0) begin
            miso     <= shiftReg[39];
            shiftReg <= {shiftReg[38:0], 1'b0};
            bitsLeft <= bitsLeft - 6'd1;
            respDone <= (bitsLeft == 6'd1);   // last bit now on miso
         end else begin
            miso <= ~holdLow;                 // idle high, low while busy
         end
      end
   end

endmodule

// File: logic/sdCardPkg.sv
// shared types of the SPI-mode sd card: bus fields, memory addressing and controller states
`include "sdCard_settings.svh"

package sdCardPkg;

   typedef logic [7:0]  byteT;
   typedef logic [5:0]  cmdIndexT;         // command index field
   typedef logic [31:0] cmdArgT;           // command argument field

   // memory addressing
   typedef logic [`MEM_BLOCK_BITS-1:0]    blockIdxT;
   typedef logic [`BLOCK_OFFSET_BITS-1:0] byteOffsetT;
   typedef logic [`MEM_BLOCK_BITS+`BLOCK_OFFSET_BITS-1:0] memAddrT;

   // response shifting, longest word is R3/R7 at 40 bits
   typedef logic [39:0] respT;
   typedef logic [5:0]  respLenT;

   typedef enum logic [3:0] {
      powerUp,       // waiting out the power-up clocks
      idle,          // listening for a command
      waitNcr,       // gap before the response
      respond,       // command response on miso
      readGap,       // 0xFF bytes before the start token
      readBlock,     // token, data bytes, crc
      writeData,     // receiving the write block
      dataResp,      // data response token
      busy           // programming, miso held low
   } cardStateT;

endpackage

// File: logic/sdCardTop.sv
// sd card top: connects command and data receivers, controller, response shifter and storage
`timescale 1ns/1ps

module sdCardTop (
   input  logic sclk,
   input  logic rstn,
   input  logic ncs,
   input  logic mosi,
   output logic miso
);
   import sdCardPkg::*;

   // command path
   logic     cmdListen;
   logic     cmdValid;
   cmdIndexT cmdIndex;
   cmdArgT   cmdArg;

   // write data path
   logic writeListen;
   logic dataByteValid;
   byteT dataByte;
   logic blockDone;

   // response path
   logic    respLoad;
   respT    respWord;
   respLenT respLen;
   logic    respDone;
   logic    holdLow;

   // storage
   logic    memWrite;
   memAddrT memAddr;
   byteT    memWData;
   byteT    memRData;

   cmdReceiver u_cmdReceiver (
      .sclk(sclk), .rstn(rstn), .ncs(ncs), .mosi(mosi), .cmdListen(cmdListen),
      .cmdValid(cmdValid), .cmdIndex(cmdIndex), .cmdArg(cmdArg)
   );

   dataReceiver u_dataReceiver (
      .sclk(sclk), .rstn(rstn), .ncs(ncs), .mosi(mosi), .writeListen(writeListen),
      .dataByteValid(dataByteValid), .dataByte(dataByte), .blockDone(blockDone)
   );

   cardController u_cardController (
      .sclk(sclk), .rstn(rstn), .ncs(ncs),
      .cmdValid(cmdValid), .cmdIndex(cmdIndex), .cmdArg(cmdArg),
      .dataByteValid(dataByteValid), .dataByte(dataByte), .blockDone(blockDone),
      .respDone(respDone), .memRData(memRData),
      .cmdListen(cmdListen), .writeListen(writeListen),
      .respLoad(respLoad), .respWord(respWord), .respLen(respLen), .holdLow(holdLow),
      .memWrite(memWrite), .memAddr(memAddr), .memWData(memWData)
   );

   responseShifter u_responseShifter (
      .sclk(sclk), .rstn(rstn), .ncs(ncs), .respLoad(respLoad), .respWord(respWord),
      .respLen(respLen), .holdLow(holdLow), .respDone(respDone), .miso(miso)
   );

   blockMemory u_blockMemory (
      .sclk(sclk), .memWrite(memWrite), .memAddr(memAddr),
      .memWData(memWData), .memRData(memRData)
   );

endmodule

// File: logic/sdCard_settings.svh
// sd card settings: block geometry, SPI timing in bytes and the fixed card registers
`ifndef SDCARD_SETTINGS_SVH
`define SDCARD_SETTINGS_SVH

// storage geometry
`define BLOCK_BYTES        16
`define BLOCK_OFFSET_BITS  4
`define MEM_BLOCK_BITS     3          // eight blocks
`define MEM_DEPTH          ((1 << `MEM_BLOCK_BITS) * `BLOCK_BYTES)

// bus timing, counted in clocks or in 0xFF bytes
`define POWERUP_CLOCKS     74
`define N_CR_BYTES         1          // command end to response
`define N_AC_BYTES         1          // read R1 to start token
`define BUSY_CYCLES        64         // miso low after a write

// card constants
`define CARD_VHS           4'b0001    // 2.7-3.6 V
`define CARD_OCR           32'h40FF_8000 // ccs set, busy clear
`define START_TOKEN        8'hFE
`define DATA_CRC           16'hAAAA
`define DATA_ACCEPTED      8'h05

`endif

// File: runSim.sh
#!/bin/sh
# builds the sd card testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f verilog.f --top-module sdCardTb -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/VsdCardTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "simulation returned status $simStatus"
   exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: verification/sdCardTb.sv
// sd card testbench that plays the SPI host from the data file and checks every card answer
`timescale 1ns/1ps
`include "sdCard_settings.svh"

module sdCardTb;

   localparam int MAX_RECS  = 32;
   localparam int MEM_BYTES = (1 << `MEM_BLOCK_BITS) * `BLOCK_BYTES;

   logic sclk;
   logic rstn;
   logic ncs;
   logic mosi;
   logic miso;

   logic [39:0] testData [0:6*MAX_RECS-1];   // six fields per record
   logic [7:0]  blockCopy [0:MEM_BYTES-1];    // host copy of every written block
   logic [16:0] lfsr;

   int          rec;
   logic [3:0]  op;
   logic [5:0]  idx;
   logic [31:0] arg;
   logic [39:0] expResp;
   int          respLen;
   int          steps;
   logic [39:0] word;
   logic        found;
   logic [7:0]  rxByte;
   logic [7:0]  txByte;
   logic [15:0] crc;
   int          lowClocks;
   int          base;

   sdCardTop u_sdCardTop (.sclk(sclk), .rstn(rstn), .ncs(ncs), .mosi(mosi), .miso(miso));

   always #20 sclk = ~sclk;

   // taps x^17 + x^14 + 1 with the new bit entering at the bottom
   function automatic logic [16:0] lfsrNext(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   task automatic abortRun();
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic checkValue(input string name, input logic [39:0] got, input logic [39:0] exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
         abortRun();
      end
   endtask

   // host samples miso and drives mosi on the falling edge
   task automatic shiftBit(input logic outBit, output logic inBit);
      @(negedge sclk);
      inBit = miso;
      mosi  = outBit;
   endtask

   task automatic shiftByte(input logic [7:0] outByte, output logic [7:0] inByte);
      logic b;
      for (int i = 7; i >= 0; i--) begin
         shiftBit(outByte[i], b);
         inByte[i] = b;
      end
   endtask

   task automatic deselect();
      @(negedge sclk);
      ncs  = 1'b1;
      mosi = 1'b1;
      repeat (8) @(negedge sclk);
      ncs = 1'b0;
   endtask

   task automatic sendCommand(input logic [5:0] cmd, input logic [31:0] cmdArg);
      logic [47:0] frame;
      logic [6:0]  crc7;
      logic        b;
      crc7 = (cmd == 6'd0) ? 7'h4A : (cmd == 6'd8) ? 7'h43 : 7'h7F;
      frame = {2'b01, cmd, cmdArg, crc7, 1'b1};
      for (int i = 47; i >= 0; i--) shiftBit(frame[i], b);
   endtask

   // first 0 bit starts the response and len-1 more bits follow
   task automatic huntResponse(input int len, output logic [39:0] resp, output logic hit);
      logic b;
      int   count;
      hit   = 1'b0;
      count = 0;
      resp  = '0;
      while (!hit && count < 16 * 8) begin
         shiftBit(1'b1, b);
         count++;
         if (b == 1'b0) hit = 1'b1;
      end
      if (hit) begin
         for (int i = 1; i < len; i++) begin
            shiftBit(1'b1, b);
            resp = {resp[38:0], b};
         end
      end
   endtask

   task automatic huntToken(output logic hit);
      logic [7:0] window;
      logic       b;
      int         count;
      window = 8'hFF;
      hit    = 1'b0;
      count  = 0;
      while (!hit && count < 8 * 8) begin
         shiftBit(1'b1, b);
         count++;
         window = {window[6:0], b};
         if (window == `START_TOKEN) hit = 1'b1;
      end
   endtask

   task automatic waitBusyEnd(output int lowCnt);
      logic b;
      logic done;
      int   count;
      lowCnt = 0;
      done   = 1'b0;
      count  = 0;
      while (!done && count < 2 * `BUSY_CYCLES) begin
         shiftBit(1'b1, b);
         count++;
         if (b) done = 1'b1;
         else lowCnt++;
      end
      if (!done) begin
         $display("card stayed busy after the write, miso never returned high");
         abortRun();
      end
   endtask

   task automatic expectR1(input string what);
      huntResponse(respLen, word, found);
      if (!found) begin
         $display("no response from the card to CMD%0d", idx);
         abortRun();
      end
      checkValue($sformatf("miso %s CMD%0d", what, idx), word, expResp);
   endtask

   initial begin
      sclk = 1'b0;
      rstn = 1'b0;
      ncs  = 1'b1;
      mosi = 1'b1;
      lfsr = 17'd78328;
      $readmemh("verification/sdCard_testdata.hex", testData);
      repeat (4) @(negedge sclk);
      rstn = 1'b1;

      rec = 0;
      op  = testData[0][3:0];
      while (op != 4'hF && rec < MAX_RECS) begin
         base    = rec * 6;
         idx     = testData[base+1][5:0];
         arg     = testData[base+2][31:0];
         expResp = testData[base+3];
         respLen = testData[base+4][7:0];
         steps   = testData[base+5][7:0];
         deselect();
         sendCommand(idx, arg);
         case (op)
            4'h0: expectR1("response");
            4'h1: begin                            // block write
               expectR1("R1");
               shiftByte(8'hFF, rxByte);
               shiftByte(`START_TOKEN, rxByte);
               repeat (steps) lfsr = lfsrNext(lfsr);
               for (int n = 0; n < `BLOCK_BYTES; n++) begin
                  for (int k = 0; k < 8; k++) begin
                     lfsr = lfsrNext(lfsr);
                     txByte = {txByte[6:0], lfsr[0]};
                  end
                  blockCopy[{arg[`MEM_BLOCK_BITS-1:0], n[`BLOCK_OFFSET_BITS-1:0]}] = txByte;
                  shiftByte(txByte, rxByte);
               end
               shiftByte(8'hFF, rxByte);           // crc bytes the card ignores
               shiftByte(8'hFF, rxByte);
               huntResponse(8, word, found);
               if (!found) begin
                  $display("no data response after the write block");
                  abortRun();
               end
               checkValue("miso data response", word, 40'h05);
               waitBusyEnd(lowClocks);
               checkValue("miso busy clocks", lowClocks, `BUSY_CYCLES);
            end
            4'h2: begin                            // block read
               expectR1("R1");
               huntToken(found);
               if (!found) begin
                  $display("no start token after CMD17");
                  abortRun();
               end
               for (int n = 0; n < `BLOCK_BYTES; n++) begin
                  shiftByte(8'hFF, rxByte);
                  checkValue($sformatf("miso read byte %0d", n), rxByte,
                     blockCopy[{arg[`MEM_BLOCK_BITS-1:0], n[`BLOCK_OFFSET_BITS-1:0]}]);
               end
               shiftByte(8'hFF, crc[15:8]);
               shiftByte(8'hFF, crc[7:0]);
               checkValue("miso read crc", crc, `DATA_CRC);
            end
            4'h3: begin                            // card must stay silent
               huntResponse(8, word, found);
               if (found) begin
                  $display("card answered CMD%0d during the power-up wait", idx);
                  abortRun();
               end
            end
            4'h4: begin                            // rejected read has no data phase
               expectR1("R1");
               huntToken(found);
               if (found) begin
                  $display("start token sent for a read that was rejected");
                  abortRun();
               end
            end
            default: begin
               $display("unknown operation %0h in the data file", op);
               abortRun();
            end
         endcase
         rec++;
         op = testData[rec*6][3:0];
      end
      deselect();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: verification/sdCard_testdata.hex
// columns: op index argument expected-response length lfsr-steps
// op 0 command, 1 write, 2 read, 3 no answer expected, 4 read rejected, F end
3 00 00000000 0000000000 08 00
0 00 00000000 0000000001 08 00
0 08 000001AA 01000001AA 28 00
0 08 000002AA 01000000AA 28 00
0 3A 00000000 0140FF8000 28 00
4 11 00000000 0000000005 08 00
0 05 00000000 0000000005 08 00
0 37 00000000 0000000001 08 00
0 29 40000000 0000000000 08 00
0 3A 00000000 00C0FF8000 28 00
1 18 00000002 0000000000 08 05
1 18 00000005 0000000000 08 0B
2 11 00000002 0000000000 08 00
2 11 00000005 0000000000 08 00
0 05 00000000 0000000004 08 00
0 37 00000000 0000000000 08 00
0 33 00000000 0000000004 08 00
F 00 00000000 0000000000 00 00

// File: verilog.f
+incdir+logic
logic/sdCardPkg.sv
logic/blockMemory.sv
logic/cmdReceiver.sv
logic/dataReceiver.sv
logic/responseShifter.sv
logic/cardController.sv
logic/sdCardTop.sv
verification/sdCardTb.sv
